//--- ldst_cfg_pkg.sv
package ldst_cfg_pkg;

	//////////////////////////////////////////////////
	// Datapath widths

	localparam int WIDTH_DATA	= 32;		// Bank word and APB bus
	localparam int WIDTH_ISSUE	= 8;		// Wraps, ordered by age only
	localparam int WIDTH_STRIDE	= 8;
	localparam int WIDTH_LEN	= 8;
	localparam int WIDTH_PADDR	= 5;		// APB byte address

	//////////////////////////////////////////////////
	// Register map

	localparam logic [WIDTH_PADDR-1:0] ADDR_CMD		= 5'h00;	// Write starts a command
	localparam logic [WIDTH_PADDR-1:0] ADDR_SHAPE	= 5'h04;	// Stride and length
	localparam logic [WIDTH_PADDR-1:0] ADDR_BASE	= 5'h08;	// Start address in the bank
	localparam logic [WIDTH_PADDR-1:0] ADDR_STDATA	= 5'h0C;	// Word written by a store
	localparam logic [WIDTH_PADDR-1:0] ADDR_STATUS	= 5'h10;	// Busy bits and issue number

	// STATUS layout, busy bits sit at the bottom
	localparam int STATUS_ISSUE_LSB	= 8;

endpackage

//--- ldst_cmd_pkg.sv
package ldst_cmd_pkg;

	//////////////////////////////////////////////////
	// CMD register fields

	localparam logic OP_LOAD	= 1'b0;
	localparam logic OP_STORE	= 1'b1;

	localparam int CMD_OP_BIT	= 0;		// Opcode position
	localparam int CMD_LANE_LSB	= 4;		// Lane index, bits 5:4

	// Gap between stride and length in SHAPE
	localparam int WIDTH_SHAPE_PAD	= ldst_cfg_pkg::WIDTH_DATA
									- ldst_cfg_pkg::WIDTH_STRIDE
									- ldst_cfg_pkg::WIDTH_LEN;

	//////////////////////////////////////////////////
	// SHAPE word, raw on the bus, split for the lanes

	typedef union packed {
		logic [ldst_cfg_pkg::WIDTH_DATA-1:0]			raw;
		struct packed {
			logic [ldst_cfg_pkg::WIDTH_STRIDE-1:0]	stride;	// Top byte
			logic [WIDTH_SHAPE_PAD-1:0]				pad;	// Kept for read-back
			logic [ldst_cfg_pkg::WIDTH_LEN-1:0]		len;	// Low byte
		} shape;
	} operand_u;

endpackage

//--- ldst_issue.sv
`timescale 1ns/1ps

module ldst_issue #(
	parameter int N_LANES		= 4,
	parameter int DEPTH_BANK	= 64,
	localparam int WIDTH_BANK	= $clog2(DEPTH_BANK)
)(
	input											clock,
	input											rst_n,
	input											psel,
	input											penable,
	input											pwrite,
	input		[ldst_cfg_pkg::WIDTH_PADDR-1:0]		paddr,
	input		[ldst_cfg_pkg::WIDTH_DATA-1:0]		pwdata,
	output	logic	[ldst_cfg_pkg::WIDTH_DATA-1:0]	prdata,
	output	logic									pready,
	output	logic									pslverr,
	input		[N_LANES-1:0]						busy,		// One per lane
	output	logic	[ldst_cfg_pkg::WIDTH_ISSUE-1:0]	next_issue_no,
	output	logic	[N_LANES-1:0]					req,		// One-cycle dispatch
	output	logic									op,
	output	logic	[ldst_cfg_pkg::WIDTH_LEN-1:0]	len,
	output	logic	[ldst_cfg_pkg::WIDTH_STRIDE-1:0]	stride,
	output	logic	[WIDTH_BANK-1:0]				base,
	output	logic	[ldst_cfg_pkg::WIDTH_DATA-1:0]	st_data,
	output	logic	[ldst_cfg_pkg::WIDTH_ISSUE-1:0]	issue_no
);
	import ldst_cfg_pkg::*;
	import ldst_cmd_pkg::*;

	localparam int WIDTH_LANE	= (N_LANES > 1) ? $clog2(N_LANES) : 1;

	operand_u					shape_q;		// SHAPE register
	logic [WIDTH_DATA-1:0]		base_q;
	logic [WIDTH_DATA-1:0]		stdata_q;
	logic [WIDTH_ISSUE-1:0]		issue_cnt;		// Number given to the next command

	logic						sel_cmd;
	logic						sel_shape;
	logic						sel_base;
	logic						sel_stdata;
	logic						sel_status;
	logic						mapped;
	logic [WIDTH_LANE-1:0]		lane_sel;
	logic						cmd_wr;
	logic						cmd_hold;
	logic						access;

	//////////////////////////////////////////////////
	// APB decode

	assign sel_cmd		= (paddr == ADDR_CMD);
	assign sel_shape	= (paddr == ADDR_SHAPE);
	assign sel_base		= (paddr == ADDR_BASE);
	assign sel_stdata	= (paddr == ADDR_STDATA);
	assign sel_status	= (paddr == ADDR_STATUS);
	assign mapped		= sel_cmd | sel_shape | sel_base | sel_stdata | sel_status;

	assign lane_sel		= pwdata[CMD_LANE_LSB +: WIDTH_LANE];
	assign cmd_wr		= psel & penable & pwrite & sel_cmd;
	assign cmd_hold		= cmd_wr & busy[lane_sel];		// Target lane still walking

	assign pready		= ~cmd_hold;
	assign pslverr		= psel & penable & ~mapped;
	assign access		= psel & penable & pready;		// Completing cycle

	//////////////////////////////////////////////////
	// Registers and issue counter

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			shape_q		<= '0;
			base_q		<= '0;
			stdata_q	<= '0;
			issue_cnt	<= '0;
		end else if (access && pwrite) begin
			if (sel_shape)
				shape_q.raw	<= pwdata;
			if (sel_base)
				base_q		<= pwdata;
			if (sel_stdata)
				stdata_q	<= pwdata;
			if (sel_cmd)
				issue_cnt	<= issue_cnt + 1'b1;	// Each accepted command once
		end
	end

	// Read mux, CMD reads as zero
	always_comb begin
		prdata = '0;
		case (paddr)
			ADDR_SHAPE:		prdata = shape_q.raw;
			ADDR_BASE:		prdata = base_q;
			ADDR_STDATA:	prdata = stdata_q;
			ADDR_STATUS: begin
				prdata[N_LANES-1:0]						= busy;
				prdata[STATUS_ISSUE_LSB +: WIDTH_ISSUE]	= issue_cnt;
			end
			default:		prdata = '0;
		endcase
	end

	//////////////////////////////////////////////////
	// Dispatch

	always_comb begin
		req = '0;
		if (cmd_wr && !cmd_hold)
			req[lane_sel] = 1'b1;
	end

	// Shared command bus, qualified by req
	assign op				= pwdata[CMD_OP_BIT];
	assign len				= shape_q.shape.len;
	assign stride			= shape_q.shape.stride;
	assign base				= base_q[WIDTH_BANK-1:0];
	assign st_data			= stdata_q;
	assign issue_no			= issue_cnt;
	assign next_issue_no	= issue_cnt;

endmodule

//--- ldst_lane.sv
`timescale 1ns/1ps

module ldst_lane #(
	parameter int DEPTH_BANK	= 64,
	parameter int DEPTH_BUFF	= 8,
	localparam int WIDTH_BANK	= $clog2(DEPTH_BANK)
)(
	input											clock,
	input											rst_n,
	input											req,
	input											op,
	input		[ldst_cfg_pkg::WIDTH_LEN-1:0]		len,
	input		[ldst_cfg_pkg::WIDTH_STRIDE-1:0]	stride,
	input		[WIDTH_BANK-1:0]					base,
	input		[ldst_cfg_pkg::WIDTH_DATA-1:0]		st_data,
	input		[ldst_cfg_pkg::WIDTH_ISSUE-1:0]		issue_no,
	output	logic									busy,
	output	logic									q_valid,
	output	logic	[ldst_cfg_pkg::WIDTH_DATA-1:0]	q_data,
	output	logic	[ldst_cfg_pkg::WIDTH_ISSUE-1:0]	q_issue_no,
	input											q_pop
);
	import ldst_cfg_pkg::*;
	import ldst_cmd_pkg::*;

	localparam int WIDTH_BUFF	= $clog2(DEPTH_BUFF);
	localparam logic [WIDTH_BUFF:0] BUFF_LIMIT = (WIDTH_BUFF+1)'(DEPTH_BUFF);

	logic						active;
	logic						op_q;
	logic [WIDTH_LEN-1:0]		remain;			// Addresses still to visit
	logic [WIDTH_STRIDE-1:0]	stride_q;
	logic [WIDTH_BANK-1:0]		addr;
	logic [WIDTH_DATA-1:0]		st_data_q;
	logic [WIDTH_ISSUE-1:0]		issue_q;
	logic						room;
	logic						step;
	logic						last_push;

	logic [WIDTH_DATA-1:0]		bank [DEPTH_BANK];
	logic [WIDTH_DATA-1:0]		rd_data;
	logic						rd_valid;

	logic [WIDTH_DATA-1:0]		q_mem_data [DEPTH_BUFF];
	logic [WIDTH_ISSUE-1:0]		q_mem_issue [DEPTH_BUFF];
	logic [WIDTH_BUFF-1:0]		wr_ptr;
	logic [WIDTH_BUFF-1:0]		rd_ptr;
	logic [WIDTH_BUFF:0]		count;
	logic						q_take;

	//////////////////////////////////////////////////
	// Address walk

	// Counts the word in flight from the bank as already queued
	assign room			= ({1'b0, count} + {{(WIDTH_BUFF+1){1'b0}}, rd_valid})
							< {1'b0, BUFF_LIMIT};
	assign step			= active & (remain != '0) & ((op_q == OP_STORE) | room);
	assign last_push	= (op_q == OP_LOAD) & (remain == '0) & rd_valid;
	assign busy			= active;

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			active	<= 1'b0;
			op_q	<= OP_LOAD;
			remain	<= '0;
		end else if (req && !active && len != '0) begin
			active	<= 1'b1;
			op_q	<= op;
			remain	<= len;
		end else if (active) begin
			if (step)
				remain	<= remain - 1'b1;
			if ((step && op_q == OP_STORE && remain == 1) || last_push)
				active	<= 1'b0;				// Store ends on its last write and a load on its last push
		end
	end

	always_ff @(posedge clock) begin
		if (req && !active) begin
			stride_q	<= stride;
			addr		<= base;
			st_data_q	<= st_data;
			issue_q		<= issue_no;
		end else if (step) begin
			addr		<= addr + WIDTH_BANK'(stride_q);	// Wraps modulo the bank size
		end
	end

	//////////////////////////////////////////////////
	// Bank, registered read

	always_ff @(posedge clock) begin
		if (step) begin
			if (op_q == OP_STORE)
				bank[addr]	<= st_data_q;
			else
				rd_data		<= bank[addr];
		end
	end

	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n)
			rd_valid	<= 1'b0;
		else
			rd_valid	<= step & (op_q == OP_LOAD);
	end

	//////////////////////////////////////////////////
	// Load result queue

	assign q_take		= q_pop & q_valid;
	assign q_valid		= (count != '0);
	assign q_data		= q_mem_data[rd_ptr];
	assign q_issue_no	= q_mem_issue[rd_ptr];

	always_ff @(posedge clock) begin
		if (rd_valid) begin
			q_mem_data[wr_ptr]	<= rd_data;
			q_mem_issue[wr_ptr]	<= issue_q;			// Held until the last push
		end
	end

	// Pointers wrap by themselves as the depth is a power of two
	always_ff @(posedge clock or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr	<= '0;
			rd_ptr	<= '0;
			count	<= '0;
		end else begin
			if (rd_valid)
				wr_ptr	<= wr_ptr + 1'b1;
			if (q_take)
				rd_ptr	<= rd_ptr + 1'b1;
			case ({rd_valid, q_take})
				2'b10:		count <= count + 1'b1;
				2'b01:		count <= count - 1'b1;
				default:	count <= count;
			endcase
		end
	end

endmodule

//--- ldst_writeback.sv
`timescale 1ns/1ps

module ldst_writeback #(
	parameter int N_LANES		= 4,
	localparam int WIDTH_LANE	= (N_LANES > 1) ? $clog2(N_LANES) : 1
)(
	input		[N_LANES-1:0]									q_valid,
	input		[N_LANES-1:0][ldst_cfg_pkg::WIDTH_DATA-1:0]		q_data,
	input		[N_LANES-1:0][ldst_cfg_pkg::WIDTH_ISSUE-1:0]	q_issue_no,
	output	logic	[N_LANES-1:0]								q_pop,
	input		[ldst_cfg_pkg::WIDTH_ISSUE-1:0]					next_issue_no,
	output	logic												wb_valid,
	input														wb_ready,
	output	logic	[ldst_cfg_pkg::WIDTH_DATA-1:0]				wb_data,
	output	logic	[ldst_cfg_pkg::WIDTH_ISSUE-1:0]				wb_issue_no,
	output	logic	[WIDTH_LANE-1:0]							wb_lane
);
	import ldst_cfg_pkg::*;

	logic [WIDTH_ISSUE-1:0]		age [N_LANES];
	logic [WIDTH_ISSUE-1:0]		best_age;
	logic [WIDTH_LANE-1:0]		sel;
	logic						found;

	//////////////////////////////////////////////////
	// Oldest head select

	// Older command, larger distance back from the issue counter
	always_comb begin
		for (int i = 0; i < N_LANES; i++)
			age[i] = next_issue_no - q_issue_no[i];
	end

	always_comb begin
		found		= 1'b0;
		sel			= '0;
		best_age	= '0;
		for (int i = 0; i < N_LANES; i++) begin
			if (q_valid[i] && (!found || age[i] > best_age)) begin	// Strict, lower lane wins ties
				found		= 1'b1;
				sel			= WIDTH_LANE'(i);
				best_age	= age[i];
			end
		end
	end

	//////////////////////////////////////////////////
	// Write-back port

	assign wb_valid		= found;
	assign wb_data		= q_data[sel];
	assign wb_issue_no	= q_issue_no[sel];
	assign wb_lane		= sel;

	always_comb begin
		q_pop = '0;
		if (wb_valid && wb_ready)
			q_pop[sel] = 1'b1;					// Only the presented lane
	end

endmodule

//--- ldst_top.sv
`timescale 1ns/1ps

module ldst_top #(
	parameter int N_LANES		= 4,
	parameter int DEPTH_BANK	= 64,
	parameter int DEPTH_BUFF	= 8,
	localparam int WIDTH_LANE	= (N_LANES > 1) ? $clog2(N_LANES) : 1
)(
	input											clock,
	input											rst_n,
	input											psel,
	input											penable,
	input											pwrite,
	input		[ldst_cfg_pkg::WIDTH_PADDR-1:0]		paddr,
	input		[ldst_cfg_pkg::WIDTH_DATA-1:0]		pwdata,
	output	logic	[ldst_cfg_pkg::WIDTH_DATA-1:0]	prdata,
	output	logic									pready,
	output	logic									pslverr,
	output	logic									wb_valid,
	input											wb_ready,
	output	logic	[ldst_cfg_pkg::WIDTH_DATA-1:0]	wb_data,
	output	logic	[ldst_cfg_pkg::WIDTH_ISSUE-1:0]	wb_issue_no,
	output	logic	[WIDTH_LANE-1:0]				wb_lane
);
	import ldst_cfg_pkg::*;

	localparam int WIDTH_BANK	= $clog2(DEPTH_BANK);

	logic [N_LANES-1:0]						busy;
	logic [N_LANES-1:0]						req;
	logic									cmd_op;
	logic [WIDTH_LEN-1:0]					cmd_len;
	logic [WIDTH_STRIDE-1:0]				cmd_stride;
	logic [WIDTH_BANK-1:0]					cmd_base;
	logic [WIDTH_DATA-1:0]					cmd_st_data;
	logic [WIDTH_ISSUE-1:0]					cmd_issue_no;
	logic [WIDTH_ISSUE-1:0]					next_issue_no;	// Age reference for the drain

	logic [N_LANES-1:0]						q_valid;
	logic [N_LANES-1:0]						q_pop;
	logic [N_LANES-1:0][WIDTH_DATA-1:0]		q_data;
	logic [N_LANES-1:0][WIDTH_ISSUE-1:0]	q_issue_no;

	ldst_issue #(
		.N_LANES(		N_LANES			),
		.DEPTH_BANK(	DEPTH_BANK		)
	) u_issue (
		.clock(			clock			),
		.rst_n(			rst_n			),
		.psel(			psel			),
		.penable(		penable			),
		.pwrite(		pwrite			),
		.paddr(			paddr			),
		.pwdata(		pwdata			),
		.prdata(		prdata			),
		.pready(		pready			),
		.pslverr(		pslverr			),
		.busy(			busy			),
		.next_issue_no(	next_issue_no	),
		.req(			req				),
		.op(			cmd_op			),
		.len(			cmd_len			),
		.stride(		cmd_stride		),
		.base(			cmd_base		),
		.st_data(		cmd_st_data		),
		.issue_no(		cmd_issue_no	)
	);

	//////////////////////////////////////////////////
	// Lanes share the command bus, req picks one

	for (genvar g = 0; g < N_LANES; g++) begin : g_lane
		ldst_lane #(
			.DEPTH_BANK(	DEPTH_BANK		),
			.DEPTH_BUFF(	DEPTH_BUFF		)
		) u_lane (
			.clock(			clock			),
			.rst_n(			rst_n			),
			.req(			req[g]			),
			.op(			cmd_op			),
			.len(			cmd_len			),
			.stride(		cmd_stride		),
			.base(			cmd_base		),
			.st_data(		cmd_st_data		),
			.issue_no(		cmd_issue_no	),
			.busy(			busy[g]			),
			.q_valid(		q_valid[g]		),
			.q_data(		q_data[g]		),
			.q_issue_no(	q_issue_no[g]	),
			.q_pop(			q_pop[g]		)
		);
	end

	ldst_writeback #(
		.N_LANES(		N_LANES			)
	) u_wb (
		.q_valid(		q_valid			),
		.q_data(		q_data			),
		.q_issue_no(	q_issue_no		),
		.q_pop(			q_pop			),
		.next_issue_no(	next_issue_no	),
		.wb_valid(		wb_valid		),
		.wb_ready(		wb_ready		),
		.wb_data(		wb_data			),
		.wb_issue_no(	wb_issue_no		),
		.wb_lane(		wb_lane			)
	);

endmodule

//--- ldst_properties.sv
`timescale 1ns/1ps

module ldst_properties #(
	parameter int N_LANES		= 4,
	localparam int WIDTH_LANE	= (N_LANES > 1) ? $clog2(N_LANES) : 1
)(
	input										clock,
	input										rst_n,
	input										pready,
	input										pslverr,
	input										wb_valid,
	input										wb_ready,
	input	[ldst_cfg_pkg::WIDTH_DATA-1:0]		wb_data,
	input	[ldst_cfg_pkg::WIDTH_ISSUE-1:0]		wb_issue_no,
	input	[WIDTH_LANE-1:0]					wb_lane
);

	//////////////////////////////////////////////////
	// APB side

	assert property (@(posedge clock) disable iff (!rst_n) pslverr |-> pready)
		else $error("pslverr seen without pready");			// Error only on a completing access

	//////////////////////////////////////////////////
	// Write-back port

	assert property (@(posedge clock) disable iff (!rst_n)
		wb_valid && !wb_ready |=> wb_valid && $stable(wb_data)
			&& $stable(wb_issue_no) && $stable(wb_lane))
		else $error("Write-back head changed while stalled");

	assert property (@(posedge clock) $rose(rst_n) |-> !wb_valid)
		else $error("wb_valid high right after reset");

endmodule

bind ldst_top ldst_properties #(
	.N_LANES(		N_LANES			)
) u_props (
	.clock(			clock			),
	.rst_n(			rst_n			),
	.pready(		pready			),
	.pslverr(		pslverr			),
	.wb_valid(		wb_valid		),
	.wb_ready(		wb_ready		),
	.wb_data(		wb_data			),
	.wb_issue_no(	wb_issue_no		),
	.wb_lane(		wb_lane			)
);

//--- ldst_tb.sv
`timescale 1ns/1ps

module ldst_tb;
	import ldst_cfg_pkg::*;
	import ldst_cmd_pkg::*;

	localparam int N_LANES		= 4;
	localparam int DEPTH_BANK	= 64;
	localparam int DEPTH_BUFF	= 8;
	localparam int WAIT_LIMIT	= 2000;		// Cycles or polls per wait

	logic						clock = 1'b0;
	logic						rst_n;
	logic						psel;
	logic						penable;
	logic						pwrite;
	logic [WIDTH_PADDR-1:0]		paddr;
	logic [WIDTH_DATA-1:0]		pwdata;
	logic [WIDTH_DATA-1:0]		prdata;
	logic						pready;
	logic						pslverr;
	logic						wb_valid;
	logic						wb_ready;
	logic [WIDTH_DATA-1:0]		wb_data;
	logic [WIDTH_ISSUE-1:0]		wb_issue_no;
	logic [$clog2(N_LANES)-1:0]	wb_lane;

	logic [31:0]				lfsr_state = 32'hf5eb_fb48;
	logic [WIDTH_DATA-1:0]		bank_model [N_LANES][DEPTH_BANK];
	int							exp_lane [$];		// Outstanding load words, in issue order
	logic [WIDTH_ISSUE-1:0]		exp_issue [$];
	logic [WIDTH_DATA-1:0]		exp_data [$];
	logic [WIDTH_ISSUE-1:0]		issue_cnt;			// Number the next command gets

	ldst_top #(
		.N_LANES(		N_LANES			),
		.DEPTH_BANK(	DEPTH_BANK		),
		.DEPTH_BUFF(	DEPTH_BUFF		)
	) u_dut (
		.clock(			clock			),
		.rst_n(			rst_n			),
		.psel(			psel			),
		.penable(		penable			),
		.pwrite(		pwrite			),
		.paddr(			paddr			),
		.pwdata(		pwdata			),
		.prdata(		prdata			),
		.pready(		pready			),
		.pslverr(		pslverr			),
		.wb_valid(		wb_valid		),
		.wb_ready(		wb_ready		),
		.wb_data(		wb_data			),
		.wb_issue_no(	wb_issue_no		),
		.wb_lane(		wb_lane			)
	);

	always #20 clock = ~clock;

	//////////////////////////////////////////////////
	// Random bits and checks

	function automatic logic [31:0] take_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr_state = lfsr_state[0] ? (lfsr_state >> 1) ^ 32'h8020_0003 : lfsr_state >> 1;
			r = {r[30:0], lfsr_state[0]};
		end
		return r;
	endfunction

	task automatic stop_run();
		$display("TEST FAIL");
		$fatal(1, "Simulation stopped at the first error");
	endtask

	task automatic check_word(input string name, input logic [WIDTH_DATA-1:0] exp,
			input logic [WIDTH_DATA-1:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected word %h, actual %h", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_issue(input string name, input logic [WIDTH_ISSUE-1:0] exp,
			input logic [WIDTH_ISSUE-1:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected issue %0d, actual %0d", name, exp, act);
			stop_run();
		end
	endtask

	task automatic check_bits(input string name, input logic [N_LANES-1:0] exp,
			input logic [N_LANES-1:0] act);
		if (act !== exp) begin
			$display("[FAIL] %s: expected busy %b, actual %b", name, exp, act);
			stop_run();
		end
	endtask

	//////////////////////////////////////////////////
	// APB driver

	task automatic apb_xfer(input logic wr, input logic [WIDTH_PADDR-1:0] addr,
			input logic [WIDTH_DATA-1:0] data, output logic [WIDTH_DATA-1:0] rdata,
			output logic err, output int waits);
		@(posedge clock);
		psel	<= 1'b1;		// Setup phase
		penable	<= 1'b0;
		pwrite	<= wr;
		paddr	<= addr;
		pwdata	<= data;
		@(posedge clock);
		penable	<= 1'b1;
		waits = 0;
		@(posedge clock);
		while (!pready) begin
			waits++;
			if (waits > WAIT_LIMIT) begin
				$display("APB access to address %h never completed", addr);
				stop_run();
			end
			@(posedge clock);
		end
		rdata	= prdata;
		err		= pslverr;
		psel	<= 1'b0;
		penable	<= 1'b0;
	endtask

	task automatic apb_write(input logic [WIDTH_PADDR-1:0] addr,
			input logic [WIDTH_DATA-1:0] data, output int waits);
		logic [WIDTH_DATA-1:0] unused;
		logic err;
		apb_xfer(1'b1, addr, data, unused, err, waits);
		if (err) begin
			$display("APB write to address %h returned pslverr", addr);
			stop_run();
		end
	endtask

	task automatic apb_read(input logic [WIDTH_PADDR-1:0] addr,
			output logic [WIDTH_DATA-1:0] rdata, output logic err);
		int waits;
		apb_xfer(1'b0, addr, '0, rdata, err, waits);
	endtask

	// Programs one command and updates the bank model or the expected words
	task automatic issue_cmd(input int lane, input logic op, input int base, input int len,
			input int stride, input logic [WIDTH_DATA-1:0] data, output int waits);
		operand_u shape;
		int addr;
		int w;
		shape.raw			= '0;
		shape.shape.stride	= WIDTH_STRIDE'(stride);
		shape.shape.len		= WIDTH_LEN'(len);
		apb_write(ADDR_SHAPE, shape.raw, w);
		apb_write(ADDR_BASE, WIDTH_DATA'(base), w);
		apb_write(ADDR_STDATA, data, w);
		for (int i = 0; i < len; i++) begin
			addr = (base + i * stride) % DEPTH_BANK;
			if (op == OP_STORE) begin
				bank_model[lane][addr] = data;
			end else begin
				exp_lane.push_back(lane);
				exp_issue.push_back(issue_cnt);
				exp_data.push_back(bank_model[lane][addr]);
			end
		end
		apb_write(ADDR_CMD, WIDTH_DATA'((lane << CMD_LANE_LSB) | op), waits);
		issue_cnt++;
	endtask

	task automatic wait_idle(input string name);
		logic [WIDTH_DATA-1:0] st;
		logic err;
		int polls;
		polls = 0;
		apb_read(ADDR_STATUS, st, err);
		while (st[N_LANES-1:0] != '0) begin
			polls++;
			if (polls > WAIT_LIMIT) begin
				$display("%s: lanes stayed busy", name);
				stop_run();
			end
			apb_read(ADDR_STATUS, st, err);
		end
	endtask

	//////////////////////////////////////////////////
	// Write-back collection

	// Oldest outstanding word of the presented lane must match
	task automatic match_word(input string name);
		int k;
		k = 0;
		while (k < exp_lane.size() && exp_lane[k] != int'(wb_lane))
			k++;
		if (k == exp_lane.size()) begin
			$display("%s: unexpected word %h from lane %0d", name, wb_data, wb_lane);
			stop_run();
		end
		check_issue(name, exp_issue[k], wb_issue_no);
		check_word(name, exp_data[k], wb_data);
		exp_lane.delete(k);
		exp_issue.delete(k);
		exp_data.delete(k);
	endtask

	task automatic collect_wb(input string name, input int n_words, input bit slow);
		int got;
		int idle;
		got = 0;
		idle = 0;
		while (got < n_words) begin
			@(posedge clock);
			if (wb_valid && wb_ready) begin
				match_word(name);
				got++;
				idle = 0;
			end else begin
				idle++;
				if (idle > WAIT_LIMIT) begin
					$display("%s: write-back stalled with %0d words missing", name, n_words - got);
					stop_run();
				end
			end
			if (slow)
				wb_ready <= (take_bits(3) == 0);		// Mostly low, queues fill
			else
				wb_ready <= take_bits(1) != 0;
		end
		wb_ready <= 1'b0;
	endtask

	task automatic fill_bank(input int lane);
		int w;
		issue_cmd(lane, OP_STORE, 0, DEPTH_BANK, 1, take_bits(32), w);
		repeat (3)
			issue_cmd(lane, OP_STORE, int'(take_bits(6)), 1 + int'(take_bits(5)),
				int'(take_bits(8)), take_bits(32), w);
	endtask

	task automatic run_loads(input string name, input int per_lane, input int min_len,
			input bit slow);
		int lane_of [16];
		int base_of [16];
		int len_of [16];
		int stride_of [16];
		int n;
		int total;
		int w;
		n = N_LANES * per_lane;
		total = 0;
		for (int k = 0; k < n; k++) begin
			lane_of[k]		= k % N_LANES;
			base_of[k]		= int'(take_bits(6));
			len_of[k]		= min_len + int'(take_bits(4));
			stride_of[k]	= int'(take_bits(8));
			total			+= len_of[k];
		end
		fork
			for (int k = 0; k < n; k++)
				issue_cmd(lane_of[k], OP_LOAD, base_of[k], len_of[k], stride_of[k], '0, w);
			collect_wb(name, total, slow);
		join
		wait_idle(name);
		if (exp_data.size() != 0) begin
			$display("%s: %0d expected words never arrived", name, exp_data.size());
			stop_run();
		end
	endtask

	//////////////////////////////////////////////////
	// Directed tests

	task automatic test_registers();
		logic [WIDTH_DATA-1:0] rd;
		logic err;
		int w;
		apb_read(ADDR_STATUS, rd, err);
		check_bits("registers", '0, rd[N_LANES-1:0]);
		check_issue("registers", '0, rd[STATUS_ISSUE_LSB +: WIDTH_ISSUE]);
		apb_write(ADDR_SHAPE, 32'h0312_a40c, w);
		apb_read(ADDR_SHAPE, rd, err);
		check_word("registers", 32'h0312_a40c, rd);
		apb_write(ADDR_BASE, 32'h0000_0137, w);
		apb_read(ADDR_BASE, rd, err);
		check_word("registers", 32'h0000_0137, rd);
		apb_write(ADDR_STDATA, 32'hdead_beef, w);
		apb_read(ADDR_STDATA, rd, err);
		check_word("registers", 32'hdead_beef, rd);
		if (err) begin
			$display("registers: mapped read returned pslverr");
			stop_run();
		end
		apb_read(5'h14, rd, err);
		if (!err) begin
			$display("registers: unmapped address gave no pslverr");
			stop_run();
		end
	endtask

	task automatic test_strided();
		int w;
		fill_bank(0);
		issue_cmd(0, OP_STORE, 50, 12, 7, 32'h5a5a_0001, w);		// Wraps past 63
		fork
			issue_cmd(0, OP_LOAD, 47, 14, 5, '0, w);
			collect_wb("strided", 14, 1'b0);
		join
		wait_idle("strided");
	endtask

	task automatic test_backpressure();
		logic [WIDTH_DATA-1:0] rd;
		logic err;
		logic [WIDTH_ISSUE-1:0] start;
		int w;
		start = issue_cnt;
		issue_cmd(1, OP_STORE, 5, 40, 1, 32'h1111_2222, w);
		apb_read(ADDR_STATUS, rd, err);
		check_bits("backpressure", N_LANES'(2), rd[N_LANES-1:0]);
		issue_cmd(1, OP_STORE, 9, 8, 3, 32'h3333_4444, w);
		if (w == 0) begin
			$display("backpressure: CMD to a busy lane completed without waiting");
			stop_run();
		end
		apb_read(ADDR_STATUS, rd, err);
		check_bits("backpressure", N_LANES'(2), rd[N_LANES-1:0]);
		check_issue("backpressure", WIDTH_ISSUE'(start + 2), rd[STATUS_ISSUE_LSB +: WIDTH_ISSUE]);
		wait_idle("backpressure");
	endtask

	task automatic test_zero_length();
		logic [WIDTH_DATA-1:0] rd;
		logic err;
		int w;
		issue_cmd(2, OP_LOAD, 3, 0, 1, '0, w);
		apb_read(ADDR_STATUS, rd, err);
		check_bits("zero_length", '0, rd[N_LANES-1:0]);
		check_issue("zero_length", issue_cnt, rd[STATUS_ISSUE_LSB +: WIDTH_ISSUE]);
		repeat (20) begin
			@(posedge clock);
			if (wb_valid) begin
				$display("zero_length: write-back appeared for an empty command");
				stop_run();
			end
		end
	endtask

	initial begin
		rst_n		= 1'b0;
		psel		= 1'b0;
		penable		= 1'b0;
		pwrite		= 1'b0;
		paddr		= '0;
		pwdata		= '0;
		wb_ready	= 1'b0;
		issue_cnt	= '0;
		repeat (5) @(posedge clock);
		rst_n <= 1'b1;
		test_registers();
		test_strided();
		test_backpressure();
		for (int l = 0; l < N_LANES; l++)
			fill_bank(l);
		run_loads("multi_lane", 2, 4, 1'b0);
		run_loads("wb_stall", 2, 12, 1'b1);
		test_zero_length();
		if (exp_data.size() == 0) begin
			$display("TEST PASS");
			$finish;
		end else begin
			$display("Words left unreceived at the end of the run");
			stop_run();
		end
	end

endmodule

//--- ldst_top.f
ldst_cfg_pkg.sv
ldst_cmd_pkg.sv
ldst_issue.sv
ldst_lane.sv
ldst_writeback.sv
ldst_top.sv
ldst_properties.sv
ldst_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal \
	--top-module ldst_tb -f ldst_top.f -o ldst_sim

./obj_dir/ldst_sim > sim.log 2>&1 || true
cat sim.log

if grep -q "TEST FAIL" sim.log; then
	echo "Simulation reported a failure"
	exit 1
fi
if ! grep -q "TEST PASS" sim.log; then
	echo "Simulation ended without a result"
	exit 1
fi
